//--- flist.f
rtl/mem_pkg.sv
rtl/axi_lite_rd_if.sv
rtl/axi_lite_wr_if.sv
rtl/axi_lite_arbiter.sv
rtl/axi_lite_ram.sv
rtl/mem_subsys_top.sv
dv/mem_subsys_props.sv
dv/mem_subsys_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run the testbench, then scan the log for failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
  --top-module mem_subsys_tb -o mem_subsys_sim > build.log 2>&1 \
  || { cat build.log; echo "TB FAILED" > sim.log; }
[ -f sim.log ] || ./obj_dir/mem_subsys_sim > sim.log 2>&1 \
  || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0

//--- dv/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

  typedef logic [mem_pkg::DATA_W-1:0] word_t;
  typedef logic [mem_pkg::RESP_W-1:0] resp_t;

  localparam int CLK_PERIOD  = 20;
  localparam int WAIT_LIMIT  = 50;
  localparam int N_WORDS     = 32;
  localparam int WATCHDOG_NS = 200 * 60 * CLK_PERIOD;  // 200 transactions, 60 cycles each

  logic                       clk_i;
  logic                       rst_i;
  logic [mem_pkg::ADDR_W-1:0] ifu_araddr_i;
  logic                       ifu_arvalid_i;
  logic                       ifu_arready_o;
  word_t                      ifu_rdata_o;
  resp_t                      ifu_rresp_o;
  logic                       ifu_rvalid_o;
  logic                       ifu_rready_i;
  logic [mem_pkg::ADDR_W-1:0] lsu_araddr_i;
  logic                       lsu_arvalid_i;
  logic                       lsu_arready_o;
  word_t                      lsu_rdata_o;
  resp_t                      lsu_rresp_o;
  logic                       lsu_rvalid_o;
  logic                       lsu_rready_i;
  logic [mem_pkg::ADDR_W-1:0] lsu_awaddr_i;
  logic                       lsu_awvalid_i;
  logic                       lsu_awready_o;
  word_t                      lsu_wdata_i;
  logic [mem_pkg::STRB_W-1:0] lsu_wstrb_i;
  logic                       lsu_wvalid_i;
  logic                       lsu_wready_o;
  resp_t                      lsu_bresp_o;
  logic                       lsu_bvalid_o;
  logic                       lsu_bready_i;

  word_t  ref_mem [mem_pkg::RAM_WORDS];  // Expected RAM contents
  word_t  addr_list [N_WORDS];
  integer seed;
  int     mismatches;
  int     timeouts;

  mem_subsys_top mem_subsys_top_i (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic report_mismatch(input string sig, input word_t got, input word_t exp);
    mismatches++;
    $display("Error at %0t ns: %s = %h, expected %h", $time, sig, got, exp);
  endtask

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                        input logic [mem_pkg::STRB_W-1:0] strb);
    word_t res;
    res = old_w;
    for (int b = 0; b < mem_pkg::STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic ifu_read(input word_t addr, output word_t data, output resp_t resp);
    int n;
    data = '0;
    resp = '1;
    @(negedge clk_i);
    ifu_araddr_i  = addr;
    ifu_arvalid_i = 1'b1;
    n = 0;
    #(CLK_PERIOD / 4);
    while (!ifu_arready_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      #(CLK_PERIOD / 4);
      n++;
    end
    @(negedge clk_i);
    ifu_arvalid_i = 1'b0;
    if (n >= WAIT_LIMIT) begin
      timeouts++;
      $display("Timeout at %0t ns: IFU read address %h was never accepted", $time, addr);
    end else begin
      n = 0;
      #(CLK_PERIOD / 4);
      while (!ifu_rvalid_o && n < WAIT_LIMIT) begin
        @(negedge clk_i);
        #(CLK_PERIOD / 4);
        n++;
      end
      if (n >= WAIT_LIMIT) begin
        timeouts++;
        $display("Timeout at %0t ns: no IFU read response for %h", $time, addr);
      end else begin
        data = ifu_rdata_o;
        resp = ifu_rresp_o;
      end
    end
  endtask

  // Hold > 0 keeps rready low that many cycles after rvalid
  task automatic lsu_read(input word_t addr, input int hold, output word_t data,
                          output resp_t resp);
    int n;
    data = '0;
    resp = '1;
    @(negedge clk_i);
    lsu_araddr_i  = addr;
    lsu_arvalid_i = 1'b1;
    lsu_rready_i  = (hold == 0);
    n = 0;
    #(CLK_PERIOD / 4);
    while (!lsu_arready_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      #(CLK_PERIOD / 4);
      n++;
    end
    @(negedge clk_i);
    lsu_arvalid_i = 1'b0;
    if (n >= WAIT_LIMIT) begin
      timeouts++;
      $display("Timeout at %0t ns: LSU read address %h was never accepted", $time, addr);
    end else begin
      n = 0;
      #(CLK_PERIOD / 4);
      while (!lsu_rvalid_o && n < WAIT_LIMIT) begin
        @(negedge clk_i);
        #(CLK_PERIOD / 4);
        n++;
      end
      if (n >= WAIT_LIMIT) begin
        timeouts++;
        $display("Timeout at %0t ns: no LSU read response for %h", $time, addr);
      end else begin
        data = lsu_rdata_o;
        resp = lsu_rresp_o;
        repeat (hold) begin
          @(negedge clk_i);
          #(CLK_PERIOD / 4);
          if (lsu_rvalid_o !== 1'b1) report_mismatch("lsu_rvalid_o", word_t'(lsu_rvalid_o), 1);
          if (lsu_rdata_o !== data) report_mismatch("lsu_rdata_o", lsu_rdata_o, data);
          if (ifu_arready_o !== 1'b0) begin
            report_mismatch("ifu_arready_o", word_t'(ifu_arready_o), 0);
          end
        end
      end
    end
    @(negedge clk_i);
    lsu_rready_i = 1'b1;
  endtask

  task automatic lsu_write(input word_t addr, input word_t data,
                           input logic [mem_pkg::STRB_W-1:0] strb, output resp_t resp);
    int n;
    resp = '1;
    @(negedge clk_i);
    lsu_awaddr_i  = addr;
    lsu_wdata_i   = data;
    lsu_wstrb_i   = strb;
    lsu_awvalid_i = 1'b1;
    lsu_wvalid_i  = 1'b1;
    n = 0;
    #(CLK_PERIOD / 4);
    while (!(lsu_awready_o && lsu_wready_o) && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      #(CLK_PERIOD / 4);
      n++;
    end
    @(negedge clk_i);
    lsu_awvalid_i = 1'b0;
    lsu_wvalid_i  = 1'b0;
    if (n >= WAIT_LIMIT) begin
      timeouts++;
      $display("Timeout at %0t ns: LSU write to %h was never accepted", $time, addr);
    end else begin
      n = 0;
      #(CLK_PERIOD / 4);
      while (!lsu_bvalid_o && n < WAIT_LIMIT) begin
        @(negedge clk_i);
        #(CLK_PERIOD / 4);
        n++;
      end
      if (n >= WAIT_LIMIT) begin
        timeouts++;
        $display("Timeout at %0t ns: no LSU write response for %h", $time, addr);
      end else begin
        resp = lsu_bresp_o;
      end
    end
  endtask

  task automatic check_read(input string sig, input word_t addr, input word_t data,
                            input resp_t resp);
    if (data !== ref_mem[addr[mem_pkg::RAM_AW+1:2]]) begin
      report_mismatch(sig, data, ref_mem[addr[mem_pkg::RAM_AW+1:2]]);
    end
    if (resp !== mem_pkg::RESP_OKAY) report_mismatch("rresp", word_t'(resp), 0);
  endtask

  task automatic test_write_readback();
    word_t data;
    resp_t resp;
    for (int i = 0; i < N_WORDS; i++) begin
      addr_list[i] = word_t'(((i * 37) % mem_pkg::RAM_WORDS) * 4);  // Word 0 included
      data = $random(seed);
      lsu_write(addr_list[i], data, 4'hf, resp);
      if (resp !== mem_pkg::RESP_OKAY) report_mismatch("lsu_bresp_o", word_t'(resp), 0);
      ref_mem[addr_list[i][mem_pkg::RAM_AW+1:2]] = data;
    end
    for (int i = 0; i < N_WORDS; i++) begin
      lsu_read(addr_list[i], 0, data, resp);
      check_read("lsu_rdata_o", addr_list[i], data, resp);
    end
  endtask

  task automatic test_ifu_readback();
    word_t data;
    resp_t resp;
    for (int i = 0; i < N_WORDS; i++) begin
      ifu_read(addr_list[i], data, resp);
      check_read("ifu_rdata_o", addr_list[i], data, resp);
    end
  endtask

  task automatic test_partial_strobe();
    word_t data;
    word_t addr;
    resp_t resp;
    addr = addr_list[1];
    data = $random(seed);
    lsu_write(addr, data, 4'b0101, resp);
    ref_mem[addr[mem_pkg::RAM_AW+1:2]] = merge_bytes(ref_mem[addr[mem_pkg::RAM_AW+1:2]],
                                                     data, 4'b0101);
    data = $random(seed);
    lsu_write(addr, data, 4'b1000, resp);
    ref_mem[addr[mem_pkg::RAM_AW+1:2]] = merge_bytes(ref_mem[addr[mem_pkg::RAM_AW+1:2]],
                                                     data, 4'b1000);
    lsu_read(addr, 0, data, resp);
    check_read("lsu_rdata_o", addr, data, resp);
  endtask

  task automatic test_contention();
    word_t d_ifu;
    word_t d_lsu;
    resp_t r_ifu;
    resp_t r_lsu;
    time   t_ifu;
    time   t_lsu;
    fork
      begin
        lsu_read(addr_list[2], 0, d_lsu, r_lsu);
        t_lsu = $time;
      end
      begin
        ifu_read(addr_list[3], d_ifu, r_ifu);
        t_ifu = $time;
      end
    join
    check_read("lsu_rdata_o", addr_list[2], d_lsu, r_lsu);
    check_read("ifu_rdata_o", addr_list[3], d_ifu, r_ifu);
    if (t_lsu >= t_ifu) begin
      mismatches++;
      $display("Error at %0t ns: LSU response did not come before the IFU response", $time);
    end
  endtask

  task automatic test_out_of_range();
    word_t data;
    resp_t resp;
    lsu_read(word_t'(mem_pkg::RAM_WORDS * 4), 0, data, resp);
    if (resp !== mem_pkg::RESP_SLVERR) report_mismatch("lsu_rresp_o", word_t'(resp), 2);
    if (data !== '0) report_mismatch("lsu_rdata_o", data, 0);
    data = $random(seed);
    lsu_write(word_t'(mem_pkg::RAM_WORDS * 4), data, 4'hf, resp);  // Would alias word 0
    if (resp !== mem_pkg::RESP_SLVERR) report_mismatch("lsu_bresp_o", word_t'(resp), 2);
    ifu_read(32'hffff_fff0, data, resp);
    if (resp !== mem_pkg::RESP_SLVERR) report_mismatch("ifu_rresp_o", word_t'(resp), 2);
    if (data !== '0) report_mismatch("ifu_rdata_o", data, 0);
    lsu_read(32'h0, 0, data, resp);
    check_read("lsu_rdata_o", 32'h0, data, resp);
  endtask

  task automatic test_back_pressure();
    word_t d_ifu;
    word_t d_lsu;
    resp_t r_ifu;
    resp_t r_lsu;
    fork
      lsu_read(addr_list[4], 5, d_lsu, r_lsu);
      begin
        repeat (2) @(negedge clk_i);
        ifu_read(addr_list[5], d_ifu, r_ifu);  // Raised while the LSU response waits
      end
    join
    check_read("lsu_rdata_o", addr_list[4], d_lsu, r_lsu);
    check_read("ifu_rdata_o", addr_list[5], d_ifu, r_ifu);
  endtask

  initial begin
    seed          = 32'h7f36_84cd;
    mismatches    = 0;
    timeouts      = 0;
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    ifu_araddr_i  = '0;
    ifu_arvalid_i = 1'b0;
    ifu_rready_i  = 1'b1;
    lsu_araddr_i  = '0;
    lsu_arvalid_i = 1'b0;
    lsu_rready_i  = 1'b1;
    lsu_awaddr_i  = '0;
    lsu_awvalid_i = 1'b0;
    lsu_wdata_i   = '0;
    lsu_wstrb_i   = '0;
    lsu_wvalid_i  = 1'b0;
    lsu_bready_i  = 1'b1;
    repeat (3) @(negedge clk_i);
    rst_i = 1'b0;
    test_write_readback();
    test_ifu_readback();
    test_partial_strobe();
    test_contention();
    test_out_of_range();
    test_back_pressure();
    @(negedge clk_i);
    $display("Mismatches: %0d, timeouts: %0d", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t ns, the tests did not finish", $time);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/mem_subsys_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_props (
  input logic                       clk_i,
  input logic                       rst_i,
  input logic                       idle_i,
  input logic                       ifu_arready_i,
  input logic                       ifu_rvalid_i,
  input logic                       lsu_arready_i,
  input logic                       lsu_rvalid_i,
  input logic                       lsu_awready_i,
  input logic                       lsu_wready_i,
  input logic                       lsu_bvalid_i,
  input logic                       mem_arvalid_i,
  input logic                       mem_rvalid_i,
  input logic                       mem_rready_i,
  input logic [mem_pkg::DATA_W-1:0] mem_rdata_i,
  input logic                       mem_awvalid_i,
  input logic                       mem_wvalid_i
);

  logic ifu_served;
  logic lsu_served;

  // Grant as seen from the master side
  assign ifu_served = ifu_arready_i | ifu_rvalid_i;
  assign lsu_served = lsu_arready_i | lsu_rvalid_i | lsu_awready_i | lsu_wready_i
                    | lsu_bvalid_i;

  one_grant_a : assert property (@(posedge clk_i) disable iff (rst_i)
    !(ifu_served && lsu_served))
    else $error("Both masters granted at once");

  // Response held with stable data until accepted
  rvalid_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
    (mem_rvalid_i && !mem_rready_i) |=> (mem_rvalid_i && $stable(mem_rdata_i)))
    else $error("RAM read response dropped or changed before rready");

  idle_quiet_a : assert property (@(posedge clk_i) disable iff (rst_i)
    idle_i |-> !(mem_arvalid_i || mem_awvalid_i || mem_wvalid_i))
    else $error("Valid driven toward the RAM with no grant");

endmodule

bind axi_lite_arbiter mem_subsys_props arbiter_props_i (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .idle_i        (state_q == IDLE),
  .ifu_arready_i (ifu_rd.arready),
  .ifu_rvalid_i  (ifu_rd.rvalid),
  .lsu_arready_i (lsu_rd.arready),
  .lsu_rvalid_i  (lsu_rd.rvalid),
  .lsu_awready_i (lsu_wr.awready),
  .lsu_wready_i  (lsu_wr.wready),
  .lsu_bvalid_i  (lsu_wr.bvalid),
  .mem_arvalid_i (mem_rd.arvalid),
  .mem_rvalid_i  (mem_rd.rvalid),
  .mem_rready_i  (mem_rd.rready),
  .mem_rdata_i   (mem_rd.rdata),
  .mem_awvalid_i (mem_wr.awvalid),
  .mem_wvalid_i  (mem_wr.wvalid)
);

`default_nettype wire

//--- rtl/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // IFU read port
  input  logic [mem_pkg::ADDR_W-1:0] ifu_araddr_i,
  input  logic                       ifu_arvalid_i,
  output logic                       ifu_arready_o,
  output logic [mem_pkg::DATA_W-1:0] ifu_rdata_o,
  output logic [mem_pkg::RESP_W-1:0] ifu_rresp_o,
  output logic                       ifu_rvalid_o,
  input  logic                       ifu_rready_i,
  // LSU read port
  input  logic [mem_pkg::ADDR_W-1:0] lsu_araddr_i,
  input  logic                       lsu_arvalid_i,
  output logic                       lsu_arready_o,
  output logic [mem_pkg::DATA_W-1:0] lsu_rdata_o,
  output logic [mem_pkg::RESP_W-1:0] lsu_rresp_o,
  output logic                       lsu_rvalid_o,
  input  logic                       lsu_rready_i,
  // LSU write port
  input  logic [mem_pkg::ADDR_W-1:0] lsu_awaddr_i,
  input  logic                       lsu_awvalid_i,
  output logic                       lsu_awready_o,
  input  logic [mem_pkg::DATA_W-1:0] lsu_wdata_i,
  input  logic [mem_pkg::STRB_W-1:0] lsu_wstrb_i,
  input  logic                       lsu_wvalid_i,
  output logic                       lsu_wready_o,
  output logic [mem_pkg::RESP_W-1:0] lsu_bresp_o,
  output logic                       lsu_bvalid_o,
  input  logic                       lsu_bready_i
);

  axi_lite_rd_if ifu_rd ();
  axi_lite_rd_if lsu_rd ();
  axi_lite_wr_if lsu_wr ();
  axi_lite_rd_if mem_rd ();  // Arbiter to RAM
  axi_lite_wr_if mem_wr ();

  assign ifu_rd.araddr  = ifu_araddr_i;
  assign ifu_rd.arvalid = ifu_arvalid_i;
  assign ifu_rd.rready  = ifu_rready_i;
  assign ifu_arready_o  = ifu_rd.arready;
  assign ifu_rdata_o    = ifu_rd.rdata;
  assign ifu_rresp_o    = ifu_rd.rresp;
  assign ifu_rvalid_o   = ifu_rd.rvalid;

  assign lsu_rd.araddr  = lsu_araddr_i;
  assign lsu_rd.arvalid = lsu_arvalid_i;
  assign lsu_rd.rready  = lsu_rready_i;
  assign lsu_arready_o  = lsu_rd.arready;
  assign lsu_rdata_o    = lsu_rd.rdata;
  assign lsu_rresp_o    = lsu_rd.rresp;
  assign lsu_rvalid_o   = lsu_rd.rvalid;

  assign lsu_wr.awaddr  = lsu_awaddr_i;
  assign lsu_wr.awvalid = lsu_awvalid_i;
  assign lsu_wr.wdata   = lsu_wdata_i;
  assign lsu_wr.wstrb   = lsu_wstrb_i;
  assign lsu_wr.wvalid  = lsu_wvalid_i;
  assign lsu_wr.bready  = lsu_bready_i;
  assign lsu_awready_o  = lsu_wr.awready;
  assign lsu_wready_o   = lsu_wr.wready;
  assign lsu_bresp_o    = lsu_wr.bresp;
  assign lsu_bvalid_o   = lsu_wr.bvalid;

  axi_lite_arbiter axi_lite_arbiter_i (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .ifu_rd (ifu_rd),
    .lsu_rd (lsu_rd),
    .lsu_wr (lsu_wr),
    .mem_rd (mem_rd),
    .mem_wr (mem_wr)
  );

  axi_lite_ram axi_lite_ram_i (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .rd    (mem_rd),
    .wr    (mem_wr)
  );

endmodule

`default_nettype wire

//--- rtl/axi_lite_ram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_ram (
  input  logic         clk_i,
  input  logic         rst_i,
  axi_lite_rd_if.slave rd,
  axi_lite_wr_if.slave wr
);

  logic [mem_pkg::DATA_W-1:0] mem_q [mem_pkg::RAM_WORDS];

  logic                       rvalid_q;
  logic [mem_pkg::DATA_W-1:0] rdata_q;
  logic [mem_pkg::RESP_W-1:0] rresp_q;
  logic                       bvalid_q;
  logic [mem_pkg::RESP_W-1:0] bresp_q;

  logic                       ar_fire;
  logic                       aw_fire;
  logic                       rd_in_range;
  logic                       wr_in_range;
  logic [mem_pkg::RAM_AW-1:0] rd_idx;
  logic [mem_pkg::RAM_AW-1:0] wr_idx;

  // Word index from byte address
  assign rd_idx = rd.araddr[mem_pkg::RAM_AW+1:2];
  assign wr_idx = wr.awaddr[mem_pkg::RAM_AW+1:2];

  // Anything above the word index bits is out of range
  assign rd_in_range = (rd.araddr[mem_pkg::ADDR_W-1:mem_pkg::RAM_AW+2] == '0);
  assign wr_in_range = (wr.awaddr[mem_pkg::ADDR_W-1:mem_pkg::RAM_AW+2] == '0);

  assign rd.arready = ~rvalid_q;  // One read response slot
  assign ar_fire    = rd.arvalid & rd.arready;

  // Address and data are taken in the same cycle
  assign wr.awready = wr.awvalid & wr.wvalid & ~bvalid_q;
  assign wr.wready  = wr.awvalid & wr.wvalid & ~bvalid_q;
  assign aw_fire    = wr.awvalid & wr.awready;

  assign rd.rvalid = rvalid_q;
  assign rd.rdata  = rdata_q;
  assign rd.rresp  = rresp_q;
  assign wr.bvalid = bvalid_q;
  assign wr.bresp  = bresp_q;

  always_ff @(posedge clk_i) begin
    if (aw_fire && wr_in_range) begin
      for (int b = 0; b < mem_pkg::STRB_W; b++) begin
        if (wr.wstrb[b]) begin
          mem_q[wr_idx][8*b +: 8] <= wr.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      rdata_q <= rd_in_range ? mem_q[rd_idx] : '0;
      rresp_q <= rd_in_range ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
    end
    if (aw_fire) begin
      bresp_q <= wr_in_range ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else if (ar_fire) begin
      rvalid_q <= 1'b1;
    end else if (rd.rready) begin
      rvalid_q <= 1'b0;  // Held until accepted
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      bvalid_q <= 1'b0;
    end else if (aw_fire) begin
      bvalid_q <= 1'b1;
    end else if (wr.bready) begin
      bvalid_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/axi_lite_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_arbiter (
  input  logic          clk_i,
  input  logic          rst_i,
  axi_lite_rd_if.slave  ifu_rd,
  axi_lite_rd_if.slave  lsu_rd,
  axi_lite_wr_if.slave  lsu_wr,
  axi_lite_rd_if.master mem_rd,
  axi_lite_wr_if.master mem_wr
);

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    IFU_RUN = 2'b01,
    LSU_RUN = 2'b10
  } state_e;

  state_e state_d;
  state_e state_q;

  logic sel_ifu;
  logic sel_lsu;
  logic ifu_req;
  logic lsu_req;
  logic rd_done;
  logic wr_done;
  logic ifu_done;
  logic lsu_done;

  assign ifu_req  = ifu_rd.arvalid;
  assign lsu_req  = lsu_rd.arvalid | lsu_wr.awvalid | lsu_wr.wvalid;
  assign rd_done  = mem_rd.rvalid & mem_rd.rready;
  assign wr_done  = mem_wr.bvalid & mem_wr.bready;
  assign ifu_done = sel_ifu & rd_done;
  assign lsu_done = sel_lsu & (rd_done | wr_done);

  assign sel_ifu = (state_q == IFU_RUN);
  assign sel_lsu = (state_q == LSU_RUN);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (lsu_req) begin
          state_d = LSU_RUN;  // LSU wins a tie
        end else if (ifu_req) begin
          state_d = IFU_RUN;
        end
      end
      IFU_RUN: begin
        if (ifu_done) begin
          state_d = IDLE;
        end
      end
      LSU_RUN: begin
        if (lsu_done) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Responses back to the IFU
  assign ifu_rd.arready = sel_ifu & mem_rd.arready;
  assign ifu_rd.rvalid  = sel_ifu & mem_rd.rvalid;
  assign ifu_rd.rdata   = {mem_pkg::DATA_W{sel_ifu}} & mem_rd.rdata;
  assign ifu_rd.rresp   = {mem_pkg::RESP_W{sel_ifu}} & mem_rd.rresp;

  // Responses back to the LSU
  assign lsu_rd.arready = sel_lsu & mem_rd.arready;
  assign lsu_rd.rvalid  = sel_lsu & mem_rd.rvalid;
  assign lsu_rd.rdata   = {mem_pkg::DATA_W{sel_lsu}} & mem_rd.rdata;
  assign lsu_rd.rresp   = {mem_pkg::RESP_W{sel_lsu}} & mem_rd.rresp;

  assign lsu_wr.awready = sel_lsu & mem_wr.awready;
  assign lsu_wr.wready  = sel_lsu & mem_wr.wready;
  assign lsu_wr.bvalid  = sel_lsu & mem_wr.bvalid;
  assign lsu_wr.bresp   = {mem_pkg::RESP_W{sel_lsu}} & mem_wr.bresp;

  // Read channel toward the RAM, AND-OR mux on the grant
  assign mem_rd.araddr  = ({mem_pkg::ADDR_W{sel_ifu}} & ifu_rd.araddr)
                        | ({mem_pkg::ADDR_W{sel_lsu}} & lsu_rd.araddr);
  assign mem_rd.arvalid = (sel_ifu & ifu_rd.arvalid) | (sel_lsu & lsu_rd.arvalid);
  assign mem_rd.rready  = (sel_ifu & ifu_rd.rready) | (sel_lsu & lsu_rd.rready);

  // Write channel is LSU only
  assign mem_wr.awaddr  = {mem_pkg::ADDR_W{sel_lsu}} & lsu_wr.awaddr;
  assign mem_wr.awvalid = sel_lsu & lsu_wr.awvalid;
  assign mem_wr.wdata   = {mem_pkg::DATA_W{sel_lsu}} & lsu_wr.wdata;
  assign mem_wr.wstrb   = {mem_pkg::STRB_W{sel_lsu}} & lsu_wr.wstrb;
  assign mem_wr.wvalid  = sel_lsu & lsu_wr.wvalid;
  assign mem_wr.bready  = sel_lsu & lsu_wr.bready;

endmodule

`default_nettype wire

//--- rtl/axi_lite_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_lite_wr_if;

  logic [mem_pkg::ADDR_W-1:0] awaddr;
  logic                       awvalid;
  logic                       awready;
  logic [mem_pkg::DATA_W-1:0] wdata;  // data width, not address width
  logic [mem_pkg::STRB_W-1:0] wstrb;
  logic                       wvalid;
  logic                       wready;
  logic [mem_pkg::RESP_W-1:0] bresp;
  logic                       bvalid;
  logic                       bready;

  modport master (
    output awaddr,
    output awvalid,
    input  awready,
    output wdata,
    output wstrb,
    output wvalid,
    input  wready,
    input  bresp,
    input  bvalid,
    output bready
  );

  modport slave (
    input  awaddr,
    input  awvalid,
    output awready,
    input  wdata,
    input  wstrb,
    input  wvalid,
    output wready,
    output bresp,
    output bvalid,
    input  bready
  );

endinterface

`default_nettype wire

//--- rtl/axi_lite_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_lite_rd_if;

  logic [mem_pkg::ADDR_W-1:0] araddr;
  logic                       arvalid;
  logic                       arready;
  logic [mem_pkg::DATA_W-1:0] rdata;
  logic [mem_pkg::RESP_W-1:0] rresp;
  logic                       rvalid;
  logic                       rready;

  modport master (
    output araddr,
    output arvalid,
    input  arready,
    input  rdata,
    input  rresp,
    input  rvalid,
    output rready
  );

  modport slave (
    input  araddr,
    input  arvalid,
    output arready,
    output rdata,
    output rresp,
    output rvalid,
    input  rready
  );

endinterface

`default_nettype wire

//--- rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  // RAM geometry, byte range 0 .. RAM_WORDS*4-1
  localparam int unsigned RAM_WORDS = 1024;
  localparam int unsigned RAM_AW    = $clog2(RAM_WORDS);

  // Response field
  localparam int unsigned RESP_W = 2;

  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
